// ==== verilog/noc_defines.svh ====
// widths assume a 4x4 mesh with two VCs; NOC_VC_W must cover NOC_N_VC and a head flit needs 2*NOC_COORD_W data bits
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// number of virtual channels sharing the single input channel
`define NOC_N_VC 2

// bits needed to index one virtual channel
`define NOC_VC_W 1

// width of one mesh coordinate, two bits give a 4x4 mesh
`define NOC_COORD_W 2

// flit payload width
// a head flit carries x_dest in the low coordinate field and y_dest just above it
`define NOC_DATA_W 32

`endif

// ==== verilog/noc_pkg.sv ====
// shared types only; widths come from the defines header, and the port enum order fixes the one-hot bit order
`default_nettype none

`include "noc_defines.svh"

package noc_pkg;

  // the five router outputs, one bit each in a port vector
  localparam int unsigned N_PORTS = 5;

  // index of a virtual channel on the input link
  typedef logic [`NOC_VC_W-1:0] vc_id_t;

  // one mesh coordinate, used for both x and y
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // flit payload, head flits hold {y_dest, x_dest} in the low bits
  typedef logic [`NOC_DATA_W-1:0] flit_data_t;

  // head_tail marks a packet made of a single flit
  typedef enum logic [1:0] {
    FLIT_HEAD,
    FLIT_BODY,
    FLIT_TAIL,
    FLIT_HEAD_TAIL
  } flit_type_t;

  // the enum value is also the bit position in port_vec_t
  typedef enum logic [2:0] {
    PORT_NORTH,
    PORT_SOUTH,
    PORT_WEST,
    PORT_EAST,
    PORT_LOCAL
  } out_port_t;

  // one-hot output port select, north at bit 0
  typedef logic [N_PORTS-1:0] port_vec_t;

  // per-VC packet tracking
  typedef enum logic {
    VC_IDLE,
    VC_IN_PKT
  } vc_state_t;

endpackage

`default_nettype wire

// ==== verilog/flit_if.sv ====
// carries one accepted flit per cycle with no ready signal, so the receiver must take it when valid is high
`timescale 1ns/1ps
`default_nettype none

interface flit_if
  import noc_pkg::*;
();

  // high only in cycles that hold an accepted flit
  logic       valid;
  vc_id_t     vc;
  flit_type_t ftype;
  flit_data_t data;

  // driven by the control block after the acceptance check
  modport sender (
    output valid,
    output vc,
    output ftype,
    output data
  );

  // sampled by the switch register stage
  modport receiver (
    input valid,
    input vc,
    input ftype,
    input data
  );

endinterface

`default_nettype wire

// ==== verilog/vc_state_ctrl.sv ====
// accepts or drops each flit in the cycle it arrives; drop_o is one cycle late and a dropped flit leaves its VC untouched
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module vc_state_ctrl
  import noc_pkg::*;
(
  input  wire             clk,
  input  wire             arst,
  input  wire             flit_valid_i,
  input  wire vc_id_t     flit_vc_i,
  input  wire flit_type_t flit_type_i,
  input  wire flit_data_t flit_data_i,
  output logic            head_accept_o,
  output logic            body_accept_o,
  flit_if.sender          flit_o,
  output logic            drop_o
);

  // one packet tracker per virtual channel
  vc_state_t vc_state_q [`NOC_N_VC];

  // state of the addressed VC and what it becomes after this flit
  vc_state_t cur_state;
  vc_state_t nxt_state;
  logic      drop_d;

  always_comb begin
    cur_state     = vc_state_q[flit_vc_i];
    nxt_state     = cur_state;
    head_accept_o = 1'b0;
    body_accept_o = 1'b0;
    drop_d        = 1'b0;

    if (flit_valid_i) begin
      unique case (cur_state)
        VC_IDLE: begin
          // only a packet start is legal on an idle VC
          if (flit_type_i == FLIT_HEAD) begin
            head_accept_o = 1'b1;
            nxt_state     = VC_IN_PKT;
          end else if (flit_type_i == FLIT_HEAD_TAIL) begin
            // a single-flit packet opens and closes in the same cycle
            head_accept_o = 1'b1;
          end else begin
            drop_d = 1'b1;
          end
        end
        VC_IN_PKT: begin
          // inside a packet only body or tail may follow
          if (flit_type_i == FLIT_BODY) begin
            body_accept_o = 1'b1;
          end else if (flit_type_i == FLIT_TAIL) begin
            body_accept_o = 1'b1;
            nxt_state     = VC_IDLE;
          end else begin
            // a second head would interleave two packets on one VC
            drop_d = 1'b1;
          end
        end
        default: begin
          drop_d = 1'b1;
        end
      endcase
    end
  end

  // only the addressed VC can change, and a drop keeps nxt_state equal to cur_state
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      vc_state_q <= '{default: VC_IDLE};
      drop_o     <= 1'b0;
    end else begin
      if (flit_valid_i) begin
        vc_state_q[flit_vc_i] <= nxt_state;
      end
      drop_o <= drop_d;
    end
  end

  // the accepted flit goes on to the switch, a dropped one shows up with valid low
  assign flit_o.valid = head_accept_o | body_accept_o;
  assign flit_o.vc    = flit_vc_i;
  assign flit_o.ftype = flit_type_i;
  assign flit_o.data  = flit_data_i;

  // the route computer relies on seeing at most one kind of accept per cycle
  a_accept_excl : assert property (
    @(posedge clk) disable iff (arst)
    !(head_accept_o && body_accept_o)
  ) else $error("head and body accept raised together");

  // a drop report must trace back to a real flit one cycle earlier
  a_drop_has_flit : assert property (
    @(posedge clk) disable iff (arst)
    drop_o |-> $past(flit_valid_i)
  ) else $error("drop_o without a flit in the previous cycle");

endmodule

`default_nettype wire

// ==== verilog/route_compute.sv ====
// X-then-Y routing for a router at (ROUTER_X_ID, ROUTER_Y_ID); body and tail flits reuse the port stored by their VC's head
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module route_compute
  import noc_pkg::*;
#(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  wire             clk,
  input  wire             arst,
  input  wire             head_accept_i,
  input  wire             body_accept_i,
  input  wire vc_id_t     vc_i,
  input  wire flit_data_t head_data_i,
  output port_vec_t       port_o
);

  // router position in coordinate width
  coord_t router_x;
  coord_t router_y;

  // destination fields of the head flit
  coord_t x_dest;
  coord_t y_dest;

  // port picked for a new head, and the port actually used this cycle
  out_port_t head_port;
  out_port_t sel_port;

  // last head route per VC
  out_port_t route_tbl_q [`NOC_N_VC];

  assign router_x = coord_t'(ROUTER_X_ID);
  assign router_y = coord_t'(ROUTER_Y_ID);

  // x sits in the lowest field, y right above it
  assign x_dest = head_data_i[`NOC_COORD_W-1:0];
  assign y_dest = head_data_i[2*`NOC_COORD_W-1:`NOC_COORD_W];

  always_comb begin
    head_port = PORT_NORTH;
    if (x_dest == router_x && y_dest == router_y) begin
      // the packet has reached its target tile
      head_port = PORT_LOCAL;
    end else if (x_dest == router_x) begin
      // x is already resolved, so travel along y
      if (y_dest < router_y) begin
        head_port = PORT_WEST;
      end else begin
        head_port = PORT_EAST;
      end
    end else begin
      // x is corrected first; a larger x lies to the south
      if (x_dest > router_x) begin
        head_port = PORT_SOUTH;
      end else begin
        head_port = PORT_NORTH;
      end
    end
  end

  // a head uses its fresh decision, everything else follows the table
  assign sel_port = head_accept_i ? head_port : route_tbl_q[vc_i];

  always_comb begin
    port_o = '0;
    if (head_accept_i || body_accept_i) begin
      // enum value doubles as the bit index
      port_o = port_vec_t'(1) << sel_port;
    end
  end

  // the new route is visible to the next flit of the same VC
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      route_tbl_q <= '{default: PORT_NORTH};
    end else if (head_accept_i) begin
      route_tbl_q[vc_i] <= head_port;
    end
  end

  // a stored entry out of the enum range would leave the port vector empty
  a_port_onehot : assert property (
    @(posedge clk) disable iff (arst)
    (head_accept_i || body_accept_i) ? $onehot(port_o) : (port_o == '0)
  ) else $error("port select does not match the accept strobes");

endmodule

`default_nettype wire

// ==== verilog/port_switch.sv ====
// one register stage with no back-pressure; payload outputs only hold meaning while port_valid_o is nonzero
`timescale 1ns/1ps
`default_nettype none

module port_switch
  import noc_pkg::*;
(
  input  wire            clk,
  input  wire            arst,
  flit_if.receiver       flit_i,
  input  wire port_vec_t port_i,
  output port_vec_t      port_valid_o,
  output flit_data_t     port_data_o,
  output vc_id_t         port_vc_o,
  output flit_type_t     port_type_o
);

  // port select masked by the flit valid, so a dropped flit reaches no port
  port_vec_t port_valid_d;

  assign port_valid_d = flit_i.valid ? port_i : '0;

  // valids are control and return to zero on reset
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      port_valid_o <= '0;
    end else begin
      port_valid_o <= port_valid_d;
    end
  end

  // payload is loaded only with an accepted flit and otherwise keeps the last one
  always_ff @(posedge clk) begin
    if (flit_i.valid) begin
      port_data_o <= flit_i.data;
      port_vc_o   <= flit_i.vc;
      port_type_o <= flit_i.ftype;
    end
  end

  // all five ports share one payload, so two valids at once would duplicate a flit
  a_valid_onehot0 : assert property (
    @(posedge clk) disable iff (arst)
    $onehot0(port_valid_o)
  ) else $error("more than one output port valid");

endmodule

`default_nettype wire

// ==== verilog/noc_input_unit.sv ====
// one router input port with no buffering or credits; every output port is assumed to accept each cycle
`timescale 1ns/1ps
`default_nettype none

module noc_input_unit
  import noc_pkg::*;
#(
  parameter int unsigned ROUTER_X_ID = 0,
  parameter int unsigned ROUTER_Y_ID = 0
) (
  input  wire             clk,
  input  wire             arst,
  input  wire             flit_valid_i,
  input  wire vc_id_t     flit_vc_i,
  input  wire flit_type_t flit_type_i,
  input  wire flit_data_t flit_data_i,
  output port_vec_t       port_valid_o,
  output flit_data_t      port_data_o,
  output vc_id_t          port_vc_o,
  output flit_type_t      port_type_o,
  output logic            drop_o
);

  // accept strobes from the control block to the route computer
  logic head_accept;
  logic body_accept;

  // combinational port choice for the flit in this cycle
  port_vec_t port_sel;

  // accepted flit between the control block and the switch
  flit_if u_flit_if ();

  // packet-order check, decides in the arrival cycle
  vc_state_ctrl u_vc_state_ctrl (
    .clk           (clk),
    .arst          (arst),
    .flit_valid_i  (flit_valid_i),
    .flit_vc_i     (flit_vc_i),
    .flit_type_i   (flit_type_i),
    .flit_data_i   (flit_data_i),
    .head_accept_o (head_accept),
    .body_accept_o (body_accept),
    .flit_o        (u_flit_if.sender),
    .drop_o        (drop_o)
  );

  // the raw payload feeds routing, it is only decoded on head_accept
  route_compute #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_route_compute (
    .clk           (clk),
    .arst          (arst),
    .head_accept_i (head_accept),
    .body_accept_i (body_accept),
    .vc_i          (flit_vc_i),
    .head_data_i   (flit_data_i),
    .port_o        (port_sel)
  );

  // the only register stage on the flit path
  port_switch u_port_switch (
    .clk          (clk),
    .arst         (arst),
    .flit_i       (u_flit_if.receiver),
    .port_i       (port_sel),
    .port_valid_o (port_valid_o),
    .port_data_o  (port_data_o),
    .port_vc_o    (port_vc_o),
    .port_type_o  (port_type_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_noc_input_unit.sv ====
// DUT sits at (1,2) of a 4x4 mesh; the reference model assumes two VCs and head destinations in data bits [3:0]
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module tb_noc_input_unit
  import noc_pkg::*;
();

  localparam int unsigned TB_X            = 1;
  localparam int unsigned TB_Y            = 2;
  localparam int unsigned RAND_PKT_CYCLES = 300;
  localparam int unsigned RAND_BAD_CYCLES = 200;
  localparam int unsigned IDLE_CYCLES     = 50;
  // reset, directed flits, packet closing and the final drain are counted generously
  localparam int unsigned STIM_LEN = 10 + 5 + RAND_PKT_CYCLES + 8 + 11 + RAND_BAD_CYCLES
                                     + IDLE_CYCLES + 4;
  localparam int unsigned TIMEOUT_CYCLES = 4 * STIM_LEN + 100;

  logic       clk;
  logic       arst;
  logic       flit_valid_i;
  vc_id_t     flit_vc_i;
  flit_type_t flit_type_i;
  flit_data_t flit_data_i;
  port_vec_t  port_valid_o;
  flit_data_t port_data_o;
  vc_id_t     port_vc_o;
  flit_type_t port_type_o;
  logic       drop_o;

  // reference model state, one entry per VC
  vc_state_t m_state [`NOC_N_VC];
  out_port_t m_route [`NOC_N_VC];
  vc_state_t m_cur;
  out_port_t m_port;
  logic      m_accept;

  // expected outputs, already delayed by the one register stage
  port_vec_t  exp_valid;
  logic       exp_drop;
  flit_data_t exp_data;
  vc_id_t     exp_vc;
  flit_type_t exp_type;

  // stimulus packet generator, separate from the model
  logic        gen_in_pkt [`NOC_N_VC];
  int unsigned gen_left [`NOC_N_VC];

  int unsigned cycle_count;
  int unsigned error_count;

  noc_input_unit #(
    .ROUTER_X_ID (TB_X),
    .ROUTER_Y_ID (TB_Y)
  ) DUT (
    .clk          (clk),
    .arst         (arst),
    .flit_valid_i (flit_valid_i),
    .flit_vc_i    (flit_vc_i),
    .flit_type_i  (flit_type_i),
    .flit_data_i  (flit_data_i),
    .port_valid_o (port_valid_o),
    .port_data_o  (port_data_o),
    .port_vc_o    (port_vc_o),
    .port_type_o  (port_type_o),
    .drop_o       (drop_o)
  );

  always #2 clk = ~clk;

  // X first, then Y; local when both coordinates match
  function automatic out_port_t route_ref(input flit_data_t data);
    coord_t dx;
    coord_t dy;
    dx = data[1:0];
    dy = data[3:2];
    if (dx == TB_X && dy == TB_Y) return PORT_LOCAL;
    if (dx == TB_X) return (dy < TB_Y) ? PORT_WEST : PORT_EAST;
    return (dx > TB_X) ? PORT_SOUTH : PORT_NORTH;
  endfunction

  // north is bit 0, then south, west, east, local
  function automatic port_vec_t port_onehot(input out_port_t p);
    case (p)
      PORT_NORTH: return 5'b00001;
      PORT_SOUTH: return 5'b00010;
      PORT_WEST:  return 5'b00100;
      PORT_EAST:  return 5'b01000;
      PORT_LOCAL: return 5'b10000;
      default:    return 5'b00000;
    endcase
  endfunction

  // random payload with the destination placed in the low bits
  function automatic flit_data_t head_data(input coord_t x, input coord_t y);
    flit_data_t d;
    d      = $urandom();
    d[1:0] = x;
    d[3:2] = y;
    return d;
  endfunction

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "run stopped after a failed check");
  endtask

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("[FAIL] t=%0t %s", $time, msg);
    end_with_failure();
  endtask

  task automatic send_flit(input logic valid, input vc_id_t vc, input flit_type_t ftype,
                           input flit_data_t data);
    @(posedge clk);
    flit_valid_i <= valid;
    flit_vc_i    <= vc;
    flit_type_i  <= ftype;
    flit_data_i  <= data;
  endtask

  // the other inputs carry noise so that only the valid keeps the outputs quiet
  task automatic send_idle();
    send_flit(1'b0, vc_id_t'($urandom_range(1)), flit_type_t'($urandom_range(3)), $urandom());
  endtask

  // next well-formed flit of the packet running on this VC
  task automatic send_packet_step(input vc_id_t vc);
    coord_t x;
    coord_t y;
    x = coord_t'($urandom_range(3));
    y = coord_t'($urandom_range(3));
    if (!gen_in_pkt[vc]) begin
      if ($urandom_range(3) == 0) begin
        send_flit(1'b1, vc, FLIT_HEAD_TAIL, head_data(x, y));
      end else begin
        gen_in_pkt[vc] = 1'b1;
        gen_left[vc]   = $urandom_range(3);
        send_flit(1'b1, vc, FLIT_HEAD, head_data(x, y));
      end
    end else if (gen_left[vc] != 0) begin
      gen_left[vc]--;
      send_flit(1'b1, vc, FLIT_BODY, $urandom());
    end else begin
      gen_in_pkt[vc] = 1'b0;
      send_flit(1'b1, vc, FLIT_TAIL, $urandom());
    end
  endtask

  // model reads the inputs the DUT samples at this edge and predicts the next outputs
  always @(posedge clk or posedge arst) begin
    if (arst) begin
      m_state   = '{default: VC_IDLE};
      m_route   = '{default: PORT_NORTH};
      exp_valid <= '0;
      exp_drop  <= 1'b0;
      exp_data  <= '0;
      exp_vc    <= '0;
      exp_type  <= FLIT_HEAD;
    end else begin
      exp_valid <= '0;
      exp_drop  <= 1'b0;
      if (flit_valid_i) begin
        m_cur    = m_state[flit_vc_i];
        m_port   = m_route[flit_vc_i];
        m_accept = 1'b0;
        if (flit_type_i == FLIT_HEAD || flit_type_i == FLIT_HEAD_TAIL) begin
          if (m_cur == VC_IDLE) begin
            m_accept             = 1'b1;
            m_port               = route_ref(flit_data_i);
            m_route[flit_vc_i] = m_port;
            if (flit_type_i == FLIT_HEAD) m_state[flit_vc_i] = VC_IN_PKT;
          end
        end else if (m_cur == VC_IN_PKT) begin
          m_accept = 1'b1;
          if (flit_type_i == FLIT_TAIL) m_state[flit_vc_i] = VC_IDLE;
        end
        if (m_accept) begin
          exp_valid <= port_onehot(m_port);
          exp_data  <= flit_data_i;
          exp_vc    <= flit_vc_i;
          exp_type  <= flit_type_i;
        end else begin
          exp_drop <= 1'b1;
        end
      end
    end
  end

  a_port_valid : assert property (
    @(posedge clk) disable iff (arst)
    port_valid_o == exp_valid
  ) else report_mismatch($sformatf("port_valid_o %b, expected %b",
                                   $sampled(port_valid_o), $sampled(exp_valid)));

  a_drop : assert property (
    @(posedge clk) disable iff (arst)
    drop_o == exp_drop
  ) else report_mismatch($sformatf("drop_o %b, expected %b",
                                   $sampled(drop_o), $sampled(exp_drop)));

  // payload only carries meaning while a port is valid
  a_payload : assert property (
    @(posedge clk) disable iff (arst)
    (exp_valid != '0) |-> (port_data_o == exp_data && port_vc_o == exp_vc &&
                           port_type_o == exp_type)
  ) else report_mismatch($sformatf("payload %h/%0d/%0d, expected %h/%0d/%0d",
                                   $sampled(port_data_o), $sampled(port_vc_o),
                                   $sampled(port_type_o), $sampled(exp_data),
                                   $sampled(exp_vc), $sampled(exp_type)));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_with_failure();
    end
  end

  initial begin
    clk          = 1'b0;
    arst         = 1'b1;
    flit_valid_i = 1'b0;
    flit_vc_i    = '0;
    flit_type_i  = FLIT_HEAD;
    flit_data_i  = '0;
    cycle_count  = 0;
    error_count  = 0;
    gen_in_pkt   = '{default: 1'b0};
    gen_left     = '{default: 0};
    void'($urandom(32'h715b_7f3b));
    repeat (10) @(posedge clk);
    arst <= 1'b0;

    // single-flit packets reaching local, north, south, west and east in turn
    send_flit(1'b1, 1'b0, FLIT_HEAD_TAIL, head_data(2'd1, 2'd2));
    send_flit(1'b1, 1'b1, FLIT_HEAD_TAIL, head_data(2'd0, 2'd2));
    send_flit(1'b1, 1'b0, FLIT_HEAD_TAIL, head_data(2'd3, 2'd2));
    send_flit(1'b1, 1'b1, FLIT_HEAD_TAIL, head_data(2'd1, 2'd0));
    send_flit(1'b1, 1'b0, FLIT_HEAD_TAIL, head_data(2'd1, 2'd3));

    // packets on both VCs interleaved flit by flit, with idle gaps
    for (int i = 0; i < RAND_PKT_CYCLES; i++) begin
      if ($urandom_range(3) == 0) begin
        send_idle();
      end else begin
        send_packet_step(vc_id_t'($urandom_range(1)));
      end
    end
    for (int v = 0; v < `NOC_N_VC; v++) begin
      while (gen_in_pkt[v]) send_packet_step(vc_id_t'(v));
    end

    // malformed flits; the drops in between must not disturb the stored routes
    send_flit(1'b1, 1'b0, FLIT_BODY, $urandom());
    send_flit(1'b1, 1'b1, FLIT_TAIL, $urandom());
    send_flit(1'b1, 1'b0, FLIT_HEAD, head_data(2'd3, 2'd0));
    send_flit(1'b1, 1'b1, FLIT_HEAD, head_data(2'd1, 2'd0));
    send_flit(1'b1, 1'b0, FLIT_HEAD, head_data(2'd0, 2'd0));
    send_flit(1'b1, 1'b0, FLIT_HEAD_TAIL, head_data(2'd1, 2'd2));
    send_flit(1'b1, 1'b0, FLIT_BODY, $urandom());
    send_flit(1'b1, 1'b1, FLIT_TAIL, $urandom());
    send_flit(1'b1, 1'b0, FLIT_TAIL, $urandom());
    send_flit(1'b1, 1'b0, FLIT_TAIL, $urandom());
    send_flit(1'b1, 1'b1, FLIT_BODY, $urandom());

    // any type on any VC, legal or not
    for (int i = 0; i < RAND_BAD_CYCLES; i++) begin
      send_flit(1'($urandom_range(1)), vc_id_t'($urandom_range(1)),
                flit_type_t'($urandom_range(3)),
                head_data(coord_t'($urandom_range(3)), coord_t'($urandom_range(3))));
    end

    repeat (IDLE_CYCLES) send_idle();
    repeat (3) @(posedge clk);

    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== noc_input_unit.f ====
+incdir+verilog
verilog/noc_pkg.sv
verilog/flit_if.sv
verilog/vc_state_ctrl.sv
verilog/route_compute.sv
verilog/port_switch.sv
verilog/noc_input_unit.sv
test/tb_noc_input_unit.sv
